// ==== build.f ====
+incdir+hw
hw/video_pkg.sv
hw/csi_ctrl_regs.sv
hw/video_source.sv
hw/frame_monitor.sv
hw/backlight_pwm.sv
hw/flash_pin_mux.sv
hw/cam_front_top.sv
tb/tb_cam_front.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run tb_cam_front with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_cam_front -o sim_tb
if [ $? -ne 0 ]; then
	echo "run_sim: Verilator compile failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "run_sim: simulation exited with status $run_status"
	exit 1
fi

# Verdict comes from the log only
if grep -q "^Everything OK$" sim.log; then
	exit 0
fi
echo "run_sim: pass line not found in sim.log"
exit 1

// ==== tb/tb_cam_front.sv ====
`timescale 1ns/100ps
`include "video_cfg.svh"

module tb_cam_front;

	import video_pkg::*;

	// Pattern geometry from the timing constants
	localparam int LINE_LEN  = `H_SYNC + `H_BACK + `H_ACTIVE + `H_FRONT;
	localparam int FRAME_LEN = LINE_LEN * (`V_SYNC + `V_BACK + `V_ACTIVE + `V_FRONT);
	localparam int WAIT_MAX  = 3 * FRAME_LEN;

	logic        w_csi_rx_clk;
	logic        w_sys_rstn;
	dev_idx_t    dev_index_i;
	dev_cmd_t    dev_cmd_i;
	dev_word_t   dev_wdata_i;
	logic        dev_wvalid_i;
	logic        sensor_vsync_i, sensor_hsync_i, sensor_dvalid_i;
	pix_data_t   sensor_data_i;
	logic        spi_ssn_i, spi_sck_i;
	logic [3:0]  spi_dq_out_i, spi_dq_oe_i, spi_dq_in_o;
	logic [1:0]  i2c_scl_i, i2c_scl_oe_i;
	logic        i2c_sda_out_i, i2c_sda_oe_i, i2c_sda_in_o;
	logic        pad_cs_o, pad_sck_o, pad_sck_oe_o;
	logic [3:0]  pad_dq_o, pad_dq_oe_o, pad_dq_in_i;
	logic        led_o, pix_rstn_o, bl_pwm_o;
	logic        vid_vsync_o, vid_href_o;
	pix_data_t   vid_data_o;

	int          err_cnt;
	int          tests_run;
	int          tests_failed;
	int          model_frames;
	logic        vs_seen;

	cam_front_top u_dut (.*);

	initial begin
		w_csi_rx_clk = 1'b0;
		forever #2 w_csi_rx_clk = ~w_csi_rx_clk;
	end

	// Frame start model sampled mid cycle away from the edge
	always @(negedge w_csi_rx_clk) begin
		if (!w_sys_rstn) begin
			model_frames = 0;
			vs_seen      = 1'b0;
		end else begin
			if (vid_vsync_o && !vs_seen)
				model_frames = model_frames + 1;
			vs_seen = vid_vsync_o;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers

	// Next edge plus drive skew
	task automatic step();
		@(posedge w_csi_rx_clk);
		#1;
	endtask

	// One-cycle write strobe
	task automatic reg_write(input dev_idx_t idx, input dev_cmd_t cmd, input dev_word_t data);
		dev_index_i  = idx;
		dev_cmd_i    = cmd;
		dev_wdata_i  = data;
		dev_wvalid_i = 1'b1;
		step();
		dev_wvalid_i = 1'b0;
	endtask

	task automatic report_mismatch(input string sig, input logic [63:0] got,
		input logic [63:0] exp);
		$display("ERR %s: got 0x%h, expected 0x%h", sig, got, exp);
		err_cnt++;
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests_run++;
		if (err_cnt == errs_before) begin
			$display("%s: pass", name);
		end else begin
			$display("%s: FAIL with %0d errors", name, err_cnt - errs_before);
			tests_failed++;
		end
	endtask

	// Needs a low sample first so a mid-sync start is skipped
	task automatic wait_vsync_rise(output bit ok);
		bit seen_low;
		ok = 1'b0;
		seen_low = 1'b0;
		for (int i = 0; i < WAIT_MAX && !ok; i++) begin
			step();
			if (!vid_vsync_o)
				seen_low = 1'b1;
			else if (seen_low)
				ok = 1'b1;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests

	task automatic pad_sharing_test();
		int         errs_before;
		logic       fe;
		dev_word_t  wd;
		dev_cmd_t   bad_cmd;
		logic       exp_cs, exp_sck, exp_sck_oe;
		logic [3:0] exp_dq, exp_dq_oe;
		errs_before = err_cnt;
		for (int i = 0; i < 24; i++) begin
			fe = 1'($urandom);
			wd = $urandom;
			wd[0] = fe;
			reg_write(`DEV_IDX_MAIN, `CMD_FLASH_EN, wd);
			// Stray writes with the opposite bit
			if ($urandom % 2 == 0) begin
				reg_write(8'(1 + $urandom % 255), `CMD_FLASH_EN, wd ^ 32'h1);
			end else begin
				bad_cmd = ($urandom % 2 == 0) ? 8'h02 : 8'(4 + $urandom % 252);
				reg_write(`DEV_IDX_MAIN, bad_cmd, wd ^ 32'h1);
			end
			spi_ssn_i     = 1'($urandom);
			spi_sck_i     = 1'($urandom);
			spi_dq_out_i  = 4'($urandom);
			spi_dq_oe_i   = 4'($urandom);
			i2c_scl_i     = 2'($urandom);
			i2c_scl_oe_i  = 2'($urandom);
			i2c_sda_out_i = 1'($urandom);
			i2c_sda_oe_i  = 1'($urandom);
			pad_dq_in_i   = 4'($urandom);
			step();
			// SPI owns everything or I2C with WPn and HOLDn high
			if (fe) begin
				exp_cs     = spi_ssn_i;
				exp_sck    = spi_sck_i;
				exp_sck_oe = 1'b1;
				exp_dq     = spi_dq_out_i;
				exp_dq_oe  = spi_dq_oe_i;
			end else begin
				exp_cs         = 1'b1;
				exp_sck        = i2c_scl_i[1];
				exp_sck_oe     = i2c_scl_oe_i[1];
				exp_dq[3:2]    = 2'b11;
				exp_dq_oe[3:2] = 2'b11;
				exp_dq[1]      = i2c_sda_out_i;
				exp_dq_oe[1]   = i2c_sda_oe_i;
				exp_dq[0]      = i2c_scl_i[0];
				exp_dq_oe[0]   = i2c_scl_oe_i[0];
			end
			if (pad_cs_o !== exp_cs)
				report_mismatch("pad_cs_o", 64'(pad_cs_o), 64'(exp_cs));
			if (pad_sck_o !== exp_sck)
				report_mismatch("pad_sck_o", 64'(pad_sck_o), 64'(exp_sck));
			if (pad_sck_oe_o !== exp_sck_oe)
				report_mismatch("pad_sck_oe_o", 64'(pad_sck_oe_o), 64'(exp_sck_oe));
			if (pad_dq_o !== exp_dq)
				report_mismatch("pad_dq_o", 64'(pad_dq_o), 64'(exp_dq));
			if (pad_dq_oe_o !== exp_dq_oe)
				report_mismatch("pad_dq_oe_o", 64'(pad_dq_oe_o), 64'(exp_dq_oe));
			if (spi_dq_in_o !== pad_dq_in_i)
				report_mismatch("spi_dq_in_o", 64'(spi_dq_in_o), 64'(pad_dq_in_i));
			if (i2c_sda_in_o !== pad_dq_in_i[1])
				report_mismatch("i2c_sda_in_o", 64'(i2c_sda_in_o), 64'(pad_dq_in_i[1]));
		end
		end_test("pad sharing", errs_before);
	endtask

	task automatic passthrough_test();
		int        errs_before;
		logic      exp_vs, exp_href;
		pix_data_t exp_data;
		errs_before = err_cnt;
		reg_write(`DEV_IDX_MAIN, `CMD_PATTERN_EN, 32'h0);
		for (int i = 0; i <= 200; i++) begin
			if (i > 0) begin
				step();
				if (vid_vsync_o !== exp_vs)
					report_mismatch("vid_vsync_o", 64'(vid_vsync_o), 64'(exp_vs));
				if (vid_href_o !== exp_href)
					report_mismatch("vid_href_o", 64'(vid_href_o), 64'(exp_href));
				if (vid_data_o !== exp_data)
					report_mismatch("vid_data_o", vid_data_o, exp_data);
			end
			sensor_vsync_i  = 1'($urandom);
			sensor_hsync_i  = 1'($urandom);
			sensor_dvalid_i = 1'($urandom);
			sensor_data_i   = {$urandom, $urandom};
			// Seen one edge later
			exp_vs   = sensor_vsync_i;
			exp_href = sensor_hsync_i && sensor_dvalid_i;
			exp_data = sensor_data_i;
		end
		sensor_vsync_i  = 1'b0;
		sensor_hsync_i  = 1'b0;
		sensor_dvalid_i = 1'b0;
		sensor_data_i   = '0;
		step();
		end_test("sensor pass-through", errs_before);
	endtask

	task automatic pattern_test();
		int   errs_before;
		bit   ok;
		bit   done;
		int   cyc, lines, pix;
		logic prev_vs, prev_href;
		errs_before = err_cnt;
		reg_write(`DEV_IDX_MAIN, `CMD_PATTERN_EN, 32'h1);
		wait_vsync_rise(ok);
		if (!ok) begin
			$display("Pattern vsync never rose within %0d cycles", WAIT_MAX);
			err_cnt++;
		end
		for (int f = 0; f < 2 && ok; f++) begin
			cyc = 0;
			lines = 0;
			pix = 0;
			done = 1'b0;
			prev_vs = 1'b1;
			prev_href = 1'b0;
			while (!done && cyc < WAIT_MAX) begin
				step();
				cyc++;
				if (vid_href_o) begin
					// New line starts the pixel index over
					if (!prev_href) begin
						lines++;
						pix = 0;
					end
					if (vid_data_o !== 64'(pix))
						report_mismatch("vid_data_o", vid_data_o, 64'(pix));
					pix++;
				end else begin
					if (prev_href && pix != `H_ACTIVE) begin
						$display("Line %0d of frame %0d had %0d href cycles instead of %0d",
							lines, f, pix, `H_ACTIVE);
						err_cnt++;
					end
					if (vid_data_o !== '0)
						report_mismatch("vid_data_o", vid_data_o, 64'h0);
				end
				if (vid_vsync_o && !prev_vs)
					done = 1'b1;
				prev_vs = vid_vsync_o;
				prev_href = vid_href_o;
			end
			if (!done) begin
				$display("Frame %0d did not end within %0d cycles", f, WAIT_MAX);
				err_cnt++;
				ok = 1'b0;
			end else begin
				if (cyc != FRAME_LEN)
					report_mismatch("vid_vsync_o period", 64'(cyc), 64'(FRAME_LEN));
				if (lines != `V_ACTIVE)
					report_mismatch("vid_href_o lines", 64'(lines), 64'(`V_ACTIVE));
			end
		end
		end_test("test pattern", errs_before);
	endtask

	task automatic pwm_test();
		int       errs_before;
		bl_duty_t duty;
		int       high_cnt;
		errs_before = err_cnt;
		for (int k = 0; k < 5; k++) begin
			// Both ends of the range and then random
			duty = (k == 0) ? 8'h00 : (k == 1) ? 8'hff : 8'($urandom);
			reg_write(`DEV_IDX_MAIN, `CMD_BL_DUTY, {24'($urandom), duty});
			high_cnt = 0;
			repeat (4096) step();
			for (int j = 0; j < 4096; j++) begin
				step();
				if (bl_pwm_o)
					high_cnt++;
			end
			if (high_cnt != int'(duty) * 16)
				report_mismatch("bl_pwm_o high count", 64'(high_cnt), 64'(int'(duty) * 16));
		end
		end_test("backlight pwm", errs_before);
	endtask

	task automatic frame_monitor_test();
		int   errs_before;
		bit   ok;
		int   hi_len;
		logic exp_led;
		logic exp_rstn;
		errs_before = err_cnt;
		// Pattern still selected from the previous test
		for (int f = 0; f < 20; f++) begin
			wait_vsync_rise(ok);
			if (!ok) begin
				$display("Frame %0d of the LED check never started", f);
				err_cnt++;
				break;
			end
			repeat (3) step();
			exp_led = model_frames[3];
			if (led_o !== exp_led)
				report_mismatch("led_o", 64'(led_o), 64'(exp_led));
		end
		// Pixel reset pulse after each sensor vsync fall
		for (int p = 0; p < 6; p++) begin
			sensor_vsync_i = 1'b0;
			repeat (4) step();
			sensor_vsync_i = 1'b1;
			hi_len = 2 + int'($urandom % 8);
			for (int j = 0; j < hi_len; j++) begin
				step();
				if (pix_rstn_o !== 1'b1)
					report_mismatch("pix_rstn_o", 64'(pix_rstn_o), 64'h1);
			end
			sensor_vsync_i = 1'b0;
			for (int j = 1; j <= 5; j++) begin
				step();
				exp_rstn = (j != 2);
				if (pix_rstn_o !== exp_rstn)
					report_mismatch("pix_rstn_o", 64'(pix_rstn_o), 64'(exp_rstn));
			end
		end
		end_test("frame monitor", errs_before);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sequence

	initial begin
		void'($urandom(32'h3dcb_a155));
		err_cnt = 0;
		tests_run = 0;
		tests_failed = 0;
		w_sys_rstn = 1'b0;
		dev_index_i = '0;
		dev_cmd_i = '0;
		dev_wdata_i = '0;
		dev_wvalid_i = 1'b0;
		sensor_vsync_i = 1'b0;
		sensor_hsync_i = 1'b0;
		sensor_dvalid_i = 1'b0;
		sensor_data_i = '0;
		spi_ssn_i = 1'b1;
		spi_sck_i = 1'b0;
		spi_dq_out_i = '0;
		spi_dq_oe_i = '0;
		i2c_scl_i = 2'b11;
		i2c_scl_oe_i = '0;
		i2c_sda_out_i = 1'b1;
		i2c_sda_oe_i = 1'b0;
		pad_dq_in_i = '0;
		repeat (4) @(posedge w_csi_rx_clk);
		#1;
		w_sys_rstn = 1'b1;

		pad_sharing_test();
		passthrough_test();
		pattern_test();
		pwm_test();
		frame_monitor_test();

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0 && tests_failed == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== hw/cam_front_top.sv ====
`timescale 1ns/100ps

module cam_front_top (
	input  logic                 w_csi_rx_clk,
	input  logic                 w_sys_rstn,

	// Device register port
	input  video_pkg::dev_idx_t  dev_index_i,
	input  video_pkg::dev_cmd_t  dev_cmd_i,
	input  video_pkg::dev_word_t dev_wdata_i,
	input  logic                 dev_wvalid_i,

	// Sensor stream
	input  logic                 sensor_vsync_i,
	input  logic                 sensor_hsync_i,
	input  logic                 sensor_dvalid_i,
	input  video_pkg::pix_data_t sensor_data_i,

	// SPI flash master
	input  logic                 spi_ssn_i,
	input  logic                 spi_sck_i,
	input  logic [3:0]           spi_dq_out_i,
	input  logic [3:0]           spi_dq_oe_i,
	output logic [3:0]           spi_dq_in_o,

	// I2C master
	input  logic [1:0]           i2c_scl_i,
	input  logic [1:0]           i2c_scl_oe_i,
	input  logic                 i2c_sda_out_i,
	input  logic                 i2c_sda_oe_i,
	output logic                 i2c_sda_in_o,

	// Shared config flash pads
	output logic                 pad_cs_o,
	output logic                 pad_sck_o,
	output logic                 pad_sck_oe_o,
	output logic [3:0]           pad_dq_o,
	output logic [3:0]           pad_dq_oe_o,
	input  logic [3:0]           pad_dq_in_i,

	// Status, backlight and video out
	output logic                 led_o,
	output logic                 pix_rstn_o,
	output logic                 bl_pwm_o,
	output logic                 vid_vsync_o,
	output logic                 vid_href_o,
	output video_pkg::pix_data_t vid_data_o
);

	import video_pkg::*;

	logic     flash_en;
	logic     pattern_en;
	bl_duty_t bl_duty;

	// Register block
	csi_ctrl_regs u_regs (
		.w_csi_rx_clk (w_csi_rx_clk),
		.w_sys_rstn   (w_sys_rstn),
		.dev_index_i  (dev_index_i),
		.dev_cmd_i    (dev_cmd_i),
		.dev_wdata_i  (dev_wdata_i),
		.dev_wvalid_i (dev_wvalid_i),
		.flash_en_o   (flash_en),
		.pattern_en_o (pattern_en),
		.bl_duty_o    (bl_duty)
	);

	// Sensor or test pattern
	video_source u_video_source (
		.w_csi_rx_clk    (w_csi_rx_clk),
		.w_sys_rstn      (w_sys_rstn),
		.pattern_en_i    (pattern_en),
		.sensor_vsync_i  (sensor_vsync_i),
		.sensor_hsync_i  (sensor_hsync_i),
		.sensor_dvalid_i (sensor_dvalid_i),
		.sensor_data_i   (sensor_data_i),
		.vid_vsync_o     (vid_vsync_o),
		.vid_href_o      (vid_href_o),
		.vid_data_o      (vid_data_o)
	);

	// LED follows the selected stream, pixel reset the raw sensor
	frame_monitor u_frame_monitor (
		.w_csi_rx_clk   (w_csi_rx_clk),
		.w_sys_rstn     (w_sys_rstn),
		.vid_vsync_i    (vid_vsync_o),
		.sensor_vsync_i (sensor_vsync_i),
		.led_o          (led_o),
		.pix_rstn_o     (pix_rstn_o)
	);

	backlight_pwm u_backlight_pwm (
		.w_csi_rx_clk (w_csi_rx_clk),
		.w_sys_rstn   (w_sys_rstn),
		.bl_duty_i    (bl_duty),
		.pwm_o        (bl_pwm_o)
	);

	flash_pin_mux u_flash_pin_mux (
		.flash_en_i    (flash_en),
		.spi_ssn_i     (spi_ssn_i),
		.spi_sck_i     (spi_sck_i),
		.spi_dq_out_i  (spi_dq_out_i),
		.spi_dq_oe_i   (spi_dq_oe_i),
		.spi_dq_in_o   (spi_dq_in_o),
		.i2c_scl_i     (i2c_scl_i),
		.i2c_scl_oe_i  (i2c_scl_oe_i),
		.i2c_sda_out_i (i2c_sda_out_i),
		.i2c_sda_oe_i  (i2c_sda_oe_i),
		.i2c_sda_in_o  (i2c_sda_in_o),
		.pad_cs_o      (pad_cs_o),
		.pad_sck_o     (pad_sck_o),
		.pad_sck_oe_o  (pad_sck_oe_o),
		.pad_dq_o      (pad_dq_o),
		.pad_dq_oe_o   (pad_dq_oe_o),
		.pad_dq_in_i   (pad_dq_in_i)
	);

endmodule

// ==== hw/flash_pin_mux.sv ====
`timescale 1ns/100ps

module flash_pin_mux (
	input  logic       flash_en_i,

	// SPI flash master
	input  logic       spi_ssn_i,
	input  logic       spi_sck_i,
	input  logic [3:0] spi_dq_out_i,
	input  logic [3:0] spi_dq_oe_i,
	output logic [3:0] spi_dq_in_o,

	// Sensor I2C, two SCL channels and one SDA
	input  logic [1:0] i2c_scl_i,
	input  logic [1:0] i2c_scl_oe_i,
	input  logic       i2c_sda_out_i,
	input  logic       i2c_sda_oe_i,
	output logic       i2c_sda_in_o,

	// Config flash pads
	output logic       pad_cs_o,
	output logic       pad_sck_o,
	output logic       pad_sck_oe_o,
	output logic [3:0] pad_dq_o,
	output logic [3:0] pad_dq_oe_o,
	input  logic [3:0] pad_dq_in_i
);

	logic [3:0] i2c_dq;
	logic [3:0] i2c_dq_oe;

	////////////////////////////////////////////////////////////////////////////
	// Pad ownership

	// I2C use of the data pads
	// D0 channel 0 SCL, D1 channel 0 SDA
	// D2 is WPn and D3 is HOLDn, both parked high
	assign i2c_dq    = {2'b11, i2c_sda_out_i, i2c_scl_i[0]};
	assign i2c_dq_oe = {2'b11, i2c_sda_oe_i, i2c_scl_oe_i[0]};

	// Flash deselected while the sensor owns the pads
	assign pad_cs_o = flash_en_i ? spi_ssn_i : 1'b1;

	// Clock pad doubles as channel 1 SCL
	assign pad_sck_o    = flash_en_i ? spi_sck_i : i2c_scl_i[1];
	assign pad_sck_oe_o = flash_en_i ? 1'b1 : i2c_scl_oe_i[1];

	assign pad_dq_o    = flash_en_i ? spi_dq_out_i : i2c_dq;
	assign pad_dq_oe_o = flash_en_i ? spi_dq_oe_i : i2c_dq_oe;

	// Return paths do not depend on the owner
	assign spi_dq_in_o  = pad_dq_in_i;
	assign i2c_sda_in_o = pad_dq_in_i[1];

endmodule

// ==== hw/backlight_pwm.sv ====
`timescale 1ns/100ps
`include "video_cfg.svh"

module backlight_pwm (
	input  logic                w_csi_rx_clk,
	input  logic                w_sys_rstn,
	input  video_pkg::bl_duty_t bl_duty_i,
	output logic                pwm_o
);

	import video_pkg::*;

	pwm_cnt_t pwm_cnt;
	pwm_cnt_t duty_level;

	// Duty scaled by 16 to span the counter
	assign duty_level = {bl_duty_i, {(`PWM_CNT_W - `BL_DUTY_W){1'b0}}};

	// 4096 cycle period, high while below the level
	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			pwm_cnt <= '0;
			pwm_o   <= 1'b0;
		end else begin
			pwm_cnt <= pwm_cnt + 1'b1;
			// Zero duty never passes, backlight off
			pwm_o   <= (duty_level > pwm_cnt);
		end
	end

endmodule

// ==== hw/frame_monitor.sv ====
`timescale 1ns/100ps
`include "video_cfg.svh"

module frame_monitor (
	input  logic w_csi_rx_clk,
	input  logic w_sys_rstn,
	input  logic vid_vsync_i,
	input  logic sensor_vsync_i,
	output logic led_o,
	output logic pix_rstn_o
);

	import video_pkg::*;

	logic [1:0] vid_vs_hist;
	logic [1:0] sen_vs_hist;
	frame_cnt_t frame_cnt;

	////////////////////////////////////////////////////////////////////////////
	// Frame start counter

	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			vid_vs_hist <= 2'b00;
			frame_cnt   <= '0;
		end else begin
			vid_vs_hist <= {vid_vs_hist[0], vid_vsync_i};
			// Rising edge seen in history
			if (vid_vs_hist == 2'b01) begin
				frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

	// Blinks once every 16 frames
	assign led_o = frame_cnt[`FRAME_CNT_W-1];

	////////////////////////////////////////////////////////////////////////////
	// Pixel domain reset

	// Short low pulse after each sensor vsync fall
	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			sen_vs_hist <= 2'b00;
			pix_rstn_o  <= 1'b1;
		end else begin
			sen_vs_hist <= {sen_vs_hist[0], sensor_vsync_i};
			pix_rstn_o  <= (sen_vs_hist != 2'b10);
		end
	end

endmodule

// ==== hw/video_source.sv ====
`timescale 1ns/100ps
`include "video_cfg.svh"

module video_source (
	input  logic                 w_csi_rx_clk,
	input  logic                 w_sys_rstn,
	input  logic                 pattern_en_i,

	// Sensor stream from the CSI receiver
	input  logic                 sensor_vsync_i,
	input  logic                 sensor_hsync_i,
	input  logic                 sensor_dvalid_i,
	input  video_pkg::pix_data_t sensor_data_i,

	// Selected stream
	output logic                 vid_vsync_o,
	output logic                 vid_href_o,
	output video_pkg::pix_data_t vid_data_o
);

	import video_pkg::*;

	line_phase_e h_phase;
	line_phase_e v_phase;
	line_pos_t   h_pos;
	line_pos_t   v_pos;
	line_pos_t   h_last;
	line_pos_t   v_last;
	logic        h_end;
	logic        line_end;
	logic        v_end;
	logic        pat_vsync;
	logic        pat_href;
	pix_data_t   pat_data;
	logic        sens_href;

	// Phase order, FRONT wraps back to SYNC
	function automatic line_phase_e next_phase(input line_phase_e ph);
		case (ph)
			SYNC:    next_phase = BACK;
			BACK:    next_phase = ACTIVE;
			ACTIVE:  next_phase = FRONT;
			default: next_phase = SYNC;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Pattern timing

	// Last position of the current horizontal phase
	always_comb begin
		case (h_phase)
			SYNC:    h_last = line_pos_t'(`H_SYNC - 1);
			BACK:    h_last = line_pos_t'(`H_BACK - 1);
			ACTIVE:  h_last = line_pos_t'(`H_ACTIVE - 1);
			default: h_last = line_pos_t'(`H_FRONT - 1);
		endcase
	end

	// Same for the vertical phase, counted in lines
	always_comb begin
		case (v_phase)
			SYNC:    v_last = line_pos_t'(`V_SYNC - 1);
			BACK:    v_last = line_pos_t'(`V_BACK - 1);
			ACTIVE:  v_last = line_pos_t'(`V_ACTIVE - 1);
			default: v_last = line_pos_t'(`V_FRONT - 1);
		endcase
	end

	assign h_end    = (h_pos == h_last);
	// Line ends on the last front porch cycle
	assign line_end = h_end && (h_phase == FRONT);
	assign v_end    = (v_pos == v_last);

	// Free running, keeps going while the sensor is selected
	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			h_phase <= SYNC;
			h_pos   <= '0;
			v_phase <= SYNC;
			v_pos   <= '0;
		end else begin
			if (h_end) begin
				h_pos   <= '0;
				h_phase <= next_phase(h_phase);
			end else begin
				h_pos <= h_pos + 1'b1;
			end
			// Vertical machine steps once per line
			if (line_end) begin
				if (v_end) begin
					v_pos   <= '0;
					v_phase <= next_phase(v_phase);
				end else begin
					v_pos <= v_pos + 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Pattern image and output select

	assign pat_vsync = (v_phase == SYNC);
	assign pat_href  = (v_phase == ACTIVE) && (h_phase == ACTIVE);
	// Pixel index in the line, h_pos starts at 0 in ACTIVE
	assign pat_data  = pat_href ? pix_data_t'(h_pos) : '0;

	// Sensor line valid needs both hsync and data valid
	assign sens_href = sensor_hsync_i && sensor_dvalid_i;

	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			vid_vsync_o <= 1'b0;
			vid_href_o  <= 1'b0;
		end else begin
			vid_vsync_o <= pattern_en_i ? pat_vsync : sensor_vsync_i;
			vid_href_o  <= pattern_en_i ? pat_href : sens_href;
		end
	end

	// Pixel payload
	always_ff @(posedge w_csi_rx_clk) begin
		vid_data_o <= pattern_en_i ? pat_data : sensor_data_i;
	end

endmodule

// ==== hw/csi_ctrl_regs.sv ====
`timescale 1ns/100ps
`include "video_cfg.svh"

module csi_ctrl_regs (
	input  logic                 w_csi_rx_clk,
	input  logic                 w_sys_rstn,

	// Device register write port
	input  video_pkg::dev_idx_t  dev_index_i,
	input  video_pkg::dev_cmd_t  dev_cmd_i,
	input  video_pkg::dev_word_t dev_wdata_i,
	input  logic                 dev_wvalid_i,

	// Control levels to the datapath
	output logic                 flash_en_o,
	output logic                 pattern_en_o,
	output video_pkg::bl_duty_t  bl_duty_o
);

	logic main_sel;
	logic wr_flash;
	logic wr_pattern;
	logic wr_duty;

	////////////////////////////////////////////////////////////////////////////
	// Write decode

	// Strobe aimed at our index
	assign main_sel = dev_wvalid_i && (dev_index_i == `DEV_IDX_MAIN);

	// One enable per known command, anything else falls through
	assign wr_flash   = main_sel && (dev_cmd_i == `CMD_FLASH_EN);
	assign wr_pattern = main_sel && (dev_cmd_i == `CMD_PATTERN_EN);
	assign wr_duty    = main_sel && (dev_cmd_i == `CMD_BL_DUTY);

	////////////////////////////////////////////////////////////////////////////
	// Register storage

	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			flash_en_o   <= 1'b0;
			pattern_en_o <= 1'b0;
			bl_duty_o    <= '0;
		end else begin
			// Pads stay with I2C until firmware asks for the flash
			if (wr_flash) begin
				flash_en_o <= dev_wdata_i[0];
			end
			// Pattern select
			if (wr_pattern) begin
				pattern_en_o <= dev_wdata_i[0];
			end
			// Low byte only
			if (wr_duty) begin
				bl_duty_o <= dev_wdata_i[`BL_DUTY_W-1:0];
			end
		end
	end

endmodule

// ==== hw/video_pkg.sv ====
`include "video_cfg.svh"

package video_pkg;

	// Pixel beat from the sensor or the pattern source
	typedef logic [`PIXEL_W-1:0] pix_data_t;

	// Device register port fields
	typedef logic [`DEV_IDX_W-1:0] dev_idx_t;
	typedef logic [`DEV_CMD_W-1:0] dev_cmd_t;
	typedef logic [`DEV_WORD_W-1:0] dev_word_t;

	// Backlight duty and its PWM counter
	typedef logic [`BL_DUTY_W-1:0] bl_duty_t;
	typedef logic [`PWM_CNT_W-1:0] pwm_cnt_t;

	// Frame starts seen, top bit on the LED
	typedef logic [`FRAME_CNT_W-1:0] frame_cnt_t;

	// Position inside a horizontal or vertical phase
	typedef logic [`LINE_POS_W-1:0] line_pos_t;

	// Phase order of a line or a frame
	typedef enum logic [1:0] {
		SYNC   = 2'd0,
		BACK   = 2'd1,
		ACTIVE = 2'd2,
		FRONT  = 2'd3
	} line_phase_e;

endpackage

// ==== hw/video_cfg.svh ====
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Bus and field widths

// Sensor pixel bus, eight RAW8 pixels per beat
`define PIXEL_W      64
`define DEV_IDX_W    8
`define DEV_CMD_W    8
`define DEV_WORD_W   32
`define BL_DUTY_W    8
`define PWM_CNT_W    12
`define FRAME_CNT_W  4
`define LINE_POS_W   8

////////////////////////////////////////////////////////////////////////////
// Device register map

// Index answered by this block
`define DEV_IDX_MAIN    8'h00
// Bit 0 hands the shared pads to the SPI flash
`define CMD_FLASH_EN    8'h00
// Bit 0 swaps the sensor stream for the test pattern
`define CMD_PATTERN_EN  8'h01
// Bits 7..0 backlight duty
`define CMD_BL_DUTY     8'h03

////////////////////////////////////////////////////////////////////////////
// Test pattern timing

// Horizontal phases in cycles, 28 per line
`define H_SYNC    4
`define H_BACK    4
`define H_ACTIVE  16
`define H_FRONT   4
// Vertical phases in lines, 9 per frame
`define V_SYNC    1
`define V_BACK    1
`define V_ACTIVE  6
`define V_FRONT   1

`endif
